/* hdl/rv_pkg.sv */
package rv_pkg;

    // Data path width of the core.
    parameter int xlen = 32;

    // Register index and data word.
    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // R-type layout, register to register.
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I-type layout, register with a 12-bit immediate.
    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // One instruction word seen through both formats.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } rv_instr_u;

    // ALU operations of the slice.
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Decoded control, 43 bits.
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        word_t     imm;
        reg_addr_t rd;
        logic      legal;
    } dec_t;

    // Major opcodes handled here.
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

endpackage

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file #(
    parameter int            register_depth = 32,
    parameter rv_pkg::word_t stack_addr     = 32'h0000_8000
) (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t a1,
    input  rv_pkg::reg_addr_t a2,
    input  rv_pkg::reg_addr_t a3,
    input  rv_pkg::word_t     wd,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2
);
    import rv_pkg::*;

    // Index of the stack pointer.
    localparam reg_addr_t x2 = 5'd2;

    // One copy per read port.
    // Each read is then a plain single-port lookup.
    word_t bank0 [register_depth];
    word_t bank1 [register_depth];

    // Stack pointer starts at the configured address.
    // Everything else powers up undefined.
    initial begin
        bank0[x2] = stack_addr;
        bank1[x2] = stack_addr;
    end

    // Both copies take every write.
    // x0 is never written.
    always_ff @(posedge clk) begin
        if (we && a3 != '0) begin
            bank0[a3] <= wd;
            bank1[a3] <= wd;
        end
    end

    // Port 1 reads bank0.
    // x0 reads as zero.
    assign rd1 = (a1 != '0) ? bank0[a1] : '0;

    // Port 2 reads bank1.
    assign rd2 = (a2 != '0) ? bank1[a2] : '0;

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  rv_pkg::rv_instr_u instr,
    output rv_pkg::dec_t      dec
);
    import rv_pkg::*;

    // Upper seven bits of a shift immediate.
    logic [6:0] shift_hi;

    // Upper seven immediate bits hold the shift variant.
    assign shift_hi = instr.i.imm12[11:5];

    always_comb begin
        // Safe default, an illegal no-op.
        dec         = '0;
        dec.alu_op  = alu_add;
        dec.rd      = instr.r.rd;

        case (instr.r.opcode)
            opc_op: begin
                // Register operands only.
                dec.use_imm = 1'b0;
                dec.imm     = '0;
                // Base funct7 is legal for every funct3.
                dec.legal   = (instr.r.funct7 == 7'b0000000);
                case (instr.r.funct3)
                    3'b000: begin
                        dec.alu_op = instr.r.funct7[5] ? alu_sub : alu_add;
                        // Alternate funct7 selects SUB.
                        if (instr.r.funct7 == 7'b0100000) begin
                            dec.legal = 1'b1;
                        end
                    end
                    3'b001: dec.alu_op = alu_sll;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b101: begin
                        dec.alu_op = instr.r.funct7[5] ? alu_sra : alu_srl;
                        // Alternate funct7 selects SRA.
                        if (instr.r.funct7 == 7'b0100000) begin
                            dec.legal = 1'b1;
                        end
                    end
                    3'b110: dec.alu_op = alu_or;
                    default: dec.alu_op = alu_and;
                endcase
            end
            opc_op_imm: begin
                // Sign-extended 12-bit immediate.
                dec.use_imm = 1'b1;
                dec.imm     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
                dec.legal   = 1'b1;
                case (instr.i.funct3)
                    3'b000: dec.alu_op = alu_add;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b110: dec.alu_op = alu_or;
                    3'b111: dec.alu_op = alu_and;
                    3'b001: begin
                        // SLLI has no variant bits.
                        dec.alu_op = alu_sll;
                        dec.legal  = (shift_hi == 7'b0000000);
                    end
                    default: begin
                        // Bit 30 picks SRAI over SRLI.
                        dec.alu_op = instr.i.imm12[10] ? alu_sra : alu_srl;
                        dec.legal  = (shift_hi == 7'b0000000) ||
                                     (shift_hi == 7'b0100000);
                    end
                endcase
            end
            default: begin
                // Opcode outside the slice.
                dec.legal = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  rv_pkg::word_t     rd1,
    input  rv_pkg::word_t     rd2,
    input  rv_pkg::dec_t      dec,
    output logic              we,
    output rv_pkg::reg_addr_t a3,
    output rv_pkg::word_t     wd,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              illegal
);
    import rv_pkg::*;

    word_t      op_b;
    word_t      result;
    logic [4:0] shamt;

    // Second operand, immediate or register.
    assign op_b  = dec.use_imm ? dec.imm : rd2;
    // Shifts only look at five bits.
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:  result = rd1 + op_b;
            alu_sub:  result = rd1 - op_b;
            alu_sll:  result = rd1 << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(rd1) < $signed(op_b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, rd1 < op_b};
            alu_xor:  result = rd1 ^ op_b;
            alu_srl:  result = rd1 >> shamt;
            alu_sra:  result = word_t'($signed(rd1) >>> shamt);
            alu_or:   result = rd1 | op_b;
            default:  result = rd1 & op_b;
        endcase
    end

    // Write port, lands at the edge closing this cycle.
    // The register file drops writes to x0.
    assign we = instr_valid & dec.legal;
    assign a3 = dec.rd;
    assign wd = result;

    // Writeback and illegal pulses, one cycle each.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= instr_valid & dec.legal;
            illegal  <= instr_valid & ~dec.legal;
        end
    end

    // Payload follows every accepted word.
    // Kept even when rd is x0.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            wb_rd   <= dec.rd;
            wb_data <= result;
        end
    end

endmodule

/* hdl/rv_exec_unit.sv */
`timescale 1ns/1ps

module rv_exec_unit #(
    parameter int            register_depth = 32,
    parameter rv_pkg::word_t stack_addr     = 32'h0000_8000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  rv_pkg::rv_instr_u instr,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              illegal
);
    import rv_pkg::*;

    // Operands read from the register file.
    word_t     rd1;
    word_t     rd2;
    // Decoded control for the current word.
    dec_t      dec;
    // Write port driven by the ALU.
    logic      we;
    reg_addr_t a3;
    word_t     wd;

    // Source fields sit at the same bits in both formats.
    register_file #(
        .register_depth (register_depth),
        .stack_addr     (stack_addr)
    ) u_register_file (
        .clk (clk),
        .we  (we),
        .a1  (instr.r.rs1),
        .a2  (instr.r.rs2),
        .a3  (a3),
        .wd  (wd),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // Decode runs alongside the register read.
    instr_decoder u_instr_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // Execute and writeback.
    exec_alu u_exec_alu (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .rd1         (rd1),
        .rd2         (rd2),
        .dec         (dec),
        .we          (we),
        .a3          (a3),
        .wd          (wd),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

endmodule

/* tb/rv_exec_checker.sv */
`timescale 1ns/1ps

module rv_exec_checker #(
    parameter rv_pkg::word_t stack_addr = 32'h0000_8000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  rv_pkg::word_t     instr,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    input  logic              illegal,
    output int                errors,
    output int                compared
);
    import rv_pkg::*;

    // Reference register file.
    word_t     model_regs [32];
    // Expected outputs for the following cycle.
    logic      armed;
    logic      exp_valid;
    logic      exp_illegal;
    reg_addr_t exp_rd;
    word_t     exp_data;

    initial begin
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        model_regs[2] = stack_addr;
        errors        = 0;
        compared      = 0;
        armed         = 1'b0;
        exp_valid     = 1'b0;
        exp_illegal   = 1'b0;
        exp_rd        = '0;
        exp_data      = '0;
    end

    // Legality per the RV32I encoding of the slice.
    function automatic logic is_legal(input word_t w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        if (w[6:0] == opc_op) begin
            return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        end
        if (w[6:0] == opc_op_imm) begin
            if (f3 == 3'b001) begin
                return f7 == 7'h00;
            end
            if (f3 == 3'b101) begin
                return f7 == 7'h00 || f7 == 7'h20;
            end
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // Reference ALU.
    function automatic word_t model_result(input word_t w, input word_t a, input word_t b_reg);
        word_t      b;
        word_t      res;
        logic [4:0] sh;
        logic       is_imm;
        is_imm = (w[6:0] == opc_op_imm);
        b      = is_imm ? {{20{w[31]}}, w[31:20]} : b_reg;
        sh     = b[4:0];
        case (w[14:12])
            3'b000:  res = (!is_imm && w[30]) ? a - b : a + b;
            3'b001:  res = a << sh;
            3'b010:  res = {31'd0, $signed(a) < $signed(b)};
            3'b011:  res = {31'd0, a < b};
            3'b100:  res = a ^ b;
            3'b101: begin
                // Bit 30 selects the arithmetic shift.
                if (w[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic compare_field(input string name, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    always @(posedge clk) begin
        word_t res;
        logic  ok;
        // Outputs still hold last cycle's result here.
        if (armed) begin
            compare_field("wb_valid", exp_valid, wb_valid);
            compare_field("illegal", exp_illegal, illegal);
            if (exp_valid) begin
                compare_field("wb_rd", exp_rd, wb_rd);
                compare_field("wb_data", exp_data, wb_data);
            end
            if (exp_valid || exp_illegal) begin
                compared++;
            end
        end
        if (rst) begin
            armed       = 1'b1;
            exp_valid   = 1'b0;
            exp_illegal = 1'b0;
        end else begin
            ok  = is_legal(instr);
            res = model_result(instr, model_regs[instr[19:15]], model_regs[instr[24:20]]);
            exp_valid   = instr_valid && ok;
            exp_illegal = instr_valid && !ok;
            exp_rd      = instr[11:7];
            exp_data    = res;
            // x0 is never written, so it stays zero.
            if (exp_valid && instr[11:7] != 5'd0) begin
                model_regs[instr[11:7]] = res;
            end
        end
    end

endmodule

/* tb/rv_exec_unit_sva.sv */
`timescale 1ns/1ps

module rv_exec_unit_sva (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic wb_valid,
    input logic illegal
);
    // Failures seen so far, read by the testbench.
    int unsigned fail_count = 0;

    // The two pulses never overlap.
    a_exclusive: assert property (@(posedge clk) disable iff (rst) !(wb_valid && illegal))
        else begin
            fail_count++;
            $error("wb_valid and illegal high in the same cycle");
        end

    // Reset clears both pulses.
    a_reset_clear: assert property (@(posedge clk) rst |=> !wb_valid && !illegal)
        else begin
            fail_count++;
            $error("pulse high in the cycle after reset");
        end

    // A strobe gives exactly one pulse one cycle later.
    a_follow: assert property (@(posedge clk) disable iff (rst)
                               instr_valid |=> (wb_valid || illegal))
        else begin
            fail_count++;
            $error("no pulse one cycle after instr_valid");
        end

    // No strobe, no pulse.
    a_quiet: assert property (@(posedge clk) disable iff (rst)
                              !instr_valid |=> !(wb_valid || illegal))
        else begin
            fail_count++;
            $error("pulse without a preceding instr_valid");
        end

endmodule

bind rv_exec_unit rv_exec_unit_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .illegal     (illegal)
);

/* tb/rv_exec_unit_tb.sv */
`timescale 1ns/1ps

module rv_exec_unit_tb;
    import rv_pkg::*;

    localparam word_t stack_addr = 32'h0000_8000;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    logic      illegal;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Counters shared with the checker.
    int errors;
    int compared;
    int issued;
    int tests;
    int bad_tests;
    int err_mark;

    // Xorshift state.
    logic [31:0] rng;

    rv_exec_unit #(
        .register_depth (32),
        .stack_addr     (stack_addr)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    rv_exec_checker #(
        .stack_addr (stack_addr)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal),
        .errors      (errors),
        .compared    (compared)
    );

    // 100 ns clock.
    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // R-type and I-type encoders.
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    // Idle cycle with junk on the instruction bus.
    task automatic idle_cycle();
        instr_valid = 1'b0;
        instr       = next_random();
        @(posedge clk);
        #1;
    endtask

    // One strobe that may follow a few random idle cycles.
    task automatic send(input word_t w, input logic allow_gap);
        int n;
        n = 0;
        while (allow_gap && (next_random() % 4 == 0) && n < 4) begin
            idle_cycle();
            n++;
        end
        instr_valid = 1'b1;
        instr       = w;
        issued++;
        @(posedge clk);
        #1;
    endtask

    // Waits until every strobe is checked and reports the test.
    task automatic finish_test(input string name);
        int n;
        n = 0;
        instr_valid = 1'b0;
        while (compared != issued && n < 16) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (compared != issued) begin
            $display("Timeout in %s: %0d of %0d results seen", name, compared, issued);
            $display("tests failed");
            $finish;
        end
        tests++;
        if (errors != err_mark) begin
            bad_tests++;
        end
        $display("%s: %0d results so far, %0d errors", name, compared, errors - err_mark);
        err_mark = errors;
    endtask

    // Read back x1 to x31 through ADD with x0.
    task automatic read_back_all();
        for (int k = 1; k < 32; k++) begin
            send(enc_r(7'h00, 5'd0, k[4:0], 3'b000, k[4:0]), 1'b1);
        end
    endtask

    initial begin
        word_t       r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [6:0]  op;
        logic [11:0] imm;
        int          sel;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rng         = 32'd36;
        issued      = 0;
        tests       = 0;
        bad_tests   = 0;
        err_mark    = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Stack pointer preset and x0.
        r = next_random();
        send(enc_i(12'd0, 5'd2, 3'b000, 5'd5), 1'b1);
        send(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd6), 1'b1);
        send(enc_i(r[11:0], 5'd2, 3'b000, 5'd0), 1'b1);
        send(enc_i(12'd0, 5'd0, 3'b000, 5'd8), 1'b1);
        finish_test("preset_and_x0");

        // Fill every register and run dependent pairs with no gap.
        for (int k = 1; k < 32; k++) begin
            r = next_random();
            send(enc_i(r[11:0], 5'd0, 3'b000, k[4:0]), 1'b1);
        end
        repeat (16) begin
            r = next_random();
            send(enc_r(7'h00, r[14:10], r[9:5], 3'b000, r[4:0]), 1'b1);
            send(enc_r(7'h00, 5'd0, r[4:0], 3'b000, r[19:15]), 1'b0);
        end
        read_back_all();
        finish_test("init_and_raw");

        // Random R-type with the alternate funct7 only where defined.
        repeat (60) begin
            r  = next_random();
            f7 = ((r[2:0] == 3'b000 || r[2:0] == 3'b101) && r[3]) ? 7'h20 : 7'h00;
            send(enc_r(f7, r[8:4], r[13:9], r[2:0], r[18:14]), 1'b1);
        end
        finish_test("r_type");

        // Random I-type where shifts get a proper upper field.
        repeat (60) begin
            r = next_random();
            case (r[2:0])
                3'b001:  imm = {7'h00, r[24:20]};
                3'b101:  imm = {(r[25] ? 7'h20 : 7'h00), r[24:20]};
                default: imm = r[31:20];
            endcase
            send(enc_i(imm, r[8:4], r[2:0], r[13:9]), 1'b1);
        end
        finish_test("i_type");

        // Unknown opcodes and bad funct7 or shift fields.
        repeat (24) begin
            r   = next_random();
            sel = next_random() % 3;
            if (sel == 0) begin
                op = r[6:0];
                if (op == opc_op || op == opc_op_imm) begin
                    op = op ^ 7'h40;
                end
                send({r[31:7], op}, 1'b1);
            end else if (sel == 1) begin
                // Alternate funct7 on a funct3 without a variant.
                // Otherwise a funct7 with bit 25 set.
                f3 = r[14:12];
                if (r[25] && f3 != 3'b000 && f3 != 3'b101) begin
                    f7 = 7'h20;
                end else begin
                    f7 = r[31:25] | 7'h01;
                end
                send(enc_r(f7, r[24:20], r[19:15], f3, r[11:7]), 1'b1);
            end else begin
                // SLLI with the SRAI variant bit.
                // Otherwise bit 25 set in the shift field.
                if (r[2] && r[26]) begin
                    imm = {7'h20, r[24:20]};
                end else begin
                    imm = {r[31:26], 1'b1, r[24:20]};
                end
                send(enc_i(imm, r[19:15], (r[2] ? 3'b001 : 3'b101), r[11:7]), 1'b1);
            end
        end
        read_back_all();
        finish_test("illegal");

        // Idle stretches with junk on the bus.
        repeat (30) begin
            sel = 1 + next_random() % 3;
            repeat (sel) idle_cycle();
            r = next_random();
            send(enc_r(7'h00, r[4:0], r[9:5], 3'b000, r[14:10]), 1'b0);
        end
        finish_test("gaps");

        $display("%0d tests, %0d with errors, %0d mismatches, %0d assertion failures",
                 tests, bad_tests, errors, u_dut.u_sva.fail_count);
        if (bad_tests == 0 && errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* rv_exec_unit.f */
hdl/rv_pkg.sv
hdl/register_file.sv
hdl/instr_decoder.sv
hdl/exec_alu.sv
hdl/rv_exec_unit.sv
tb/rv_exec_checker.sv
tb/rv_exec_unit_sva.sv
tb/rv_exec_unit_tb.sv

/* Bender.yml */
package:
  name: rv_exec_unit

sources:
  - hdl/rv_pkg.sv
  - hdl/register_file.sv
  - hdl/instr_decoder.sv
  - hdl/exec_alu.sv
  - hdl/rv_exec_unit.sv
  - target: test
    files:
      - tb/rv_exec_checker.sv
      - tb/rv_exec_unit_sva.sv
      - tb/rv_exec_unit_tb.sv
